// ==== filelist.f ====
verilog/osf_pkg.sv
verilog/oversample_filter.sv
verilog/osf_result_buffer.sv
verilog/osf_credit_arbiter.sv
verilog/osf_top.sv
verification/osf_checker.sv
verification/osf_tb.sv

// ==== verification/osf_tb.sv ====
`timescale 1ns/1ps

module osf_tb;

	localparam int N_CH        = osf_pkg::N_CH;
	localparam int CREDITS     = 4;
	localparam int STIM_CYCLES = 200 + 400 + 2 * 4000 + 1500 + 700;  // all behaviors
	localparam int CYCLE_LIMIT = STIM_CYCLES + 2000;

	logic                  clk_in = 1'b0;
	logic                  reset_in;
	osf_pkg::osf_sample_t  sample;
	logic                  sample_valid;
	logic [N_CH-1:0]       activate;
	logic [N_CH-1:0]       update_en;
	logic                  update;
	osf_pkg::os_t          os_set;
	osf_pkg::delay_t       delay_set;
	logic                  credit_return;
	osf_pkg::osf_result_t  result;
	logic                  result_valid;
	logic [N_CH-1:0]       overflow;

	// stimulus controls applied by run_cycle
	logic [N_CH-1:0] act;
	logic [N_CH-1:0] ch_mask;     // channels allowed on the bus
	logic [N_CH-1:0] upd_mask;
	bit              upd_req;
	int              upd_os;
	int              upd_delay;
	bit              hold;        // sink keeps its credits

	// reference model
	osf_pkg::osf_state_t m_state [N_CH];
	int                  m_cnt [N_CH];
	longint              m_acc [N_CH];
	int                  m_os [N_CH];
	int                  m_delay [N_CH];
	int                  m_win [N_CH];     // windows closed so far
	longint              exp_q [N_CH][$];  // expected words per channel

	int cycles;
	int outstanding;   // words the sink holds
	int due_q [$];     // cycle numbers for credit returns
	int win_base [N_CH];
	int round_mask;

	osf_top #(
		.CREDITS(CREDITS)
	) i_dut (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.sample        (sample),
		.sample_valid  (sample_valid),
		.activate      (activate),
		.update_en     (update_en),
		.update        (update),
		.os_set        (os_set),
		.delay_set     (delay_set),
		.credit_return (credit_return),
		.result        (result),
		.result_valid  (result_valid),
		.overflow      (overflow)
	);

	always #50 clk_in = ~clk_in;   // 100 ns period

	task automatic check(input string what, input longint got, input longint exp);
		if (got !== exp) begin
			$display("** Error %0t: %s is %0d, expected %0d", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic fail_now(input string msg);
		$display("%s (time %0t)", msg, $time);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// floor of s / 2^os
	function automatic longint floor_avg(input longint s, input int os);
		longint n;
		n = longint'(1) << os;
		if (s >= 0)
			return s / n;
		return -((-s + n - 1) / n);
	endfunction

	////////////////////
	// reference model
	////////////////////

	// one clock edge of every channel with the inputs driven for it
	task automatic model_step(input bit v, input int ch, input longint d);
		bit                  hit;
		osf_pkg::osf_state_t settle;
		for (int c = 0; c < N_CH; c++) begin
			hit    = v && (ch == c);
			settle = (m_delay[c] == 0) ? osf_pkg::OSF_SAMPLE : osf_pkg::OSF_DELAY;
			if (!act[c]) begin
				m_state[c] = osf_pkg::OSF_IDLE;   // partial window lost
				m_cnt[c]   = 0;
				m_acc[c]   = 0;
			end else begin
				case (m_state[c])
					osf_pkg::OSF_IDLE: begin
						m_state[c] = settle;    // activation edge takes no sample
						m_cnt[c]   = 0;
						m_acc[c]   = 0;
					end
					osf_pkg::OSF_DELAY: begin
						if (hit)
							m_cnt[c]++;
						if (m_cnt[c] >= m_delay[c]) begin
							m_state[c] = osf_pkg::OSF_SAMPLE;
							m_cnt[c]   = 0;
						end
					end
					default: begin
						if (hit && m_cnt[c] == (1 << m_os[c]) - 1) begin
							exp_q[c].push_back(floor_avg(m_acc[c] + d, m_os[c]));
							m_win[c]++;
							m_state[c] = settle;
							m_cnt[c]   = 0;
							m_acc[c]   = 0;
						end else if (hit) begin
							m_acc[c] += d;
							m_cnt[c]++;
						end
					end
				endcase
			end
			if (upd_req && upd_mask[c]) begin   // latched after this edge's step
				m_os[c]    = upd_os;
				m_delay[c] = upd_delay;
			end
		end
	endtask

	////////////////////
	// one clock cycle
	////////////////////

	task automatic run_cycle(input bit send);
		int              ch;
		int              c;
		bit              v;
		longint          e;
		osf_pkg::sample_t r;
		@(posedge clk_in);
		#1;
		cycles++;
		if (cycles > CYCLE_LIMIT)
			fail_now("timeout, the run did not finish in time");
		// sink side
		if (result_valid) begin
			c = int'(result.chan);
			if (exp_q[c].size() == 0)
				fail_now($sformatf("result word on channel %0d with none expected", c));
			e = exp_q[c].pop_front();
			check($sformatf("result on channel %0d", c), result.data, e);
			outstanding++;
			if (outstanding > CREDITS)
				fail_now("more result words than sink credits");
			due_q.push_back(cycles + $urandom_range(3));
		end
		check("overflow", overflow, 0);
		if (i_dut.i_checker.fail_cnt != 0)
			fail_now("an assertion in the bound checker failed");
		credit_return = 1'b0;
		if (!hold && due_q.size() > 0 && due_q[0] <= cycles) begin
			credit_return = 1'b1;   // one slot freed
			void'(due_q.pop_front());
			outstanding--;
		end
		// bus side carries a sample about half the cycles
		v  = send && ($urandom_range(1) == 1);
		ch = $urandom_range(N_CH - 1);
		r  = osf_pkg::sample_t'($urandom);
		if (!ch_mask[ch])
			v = 1'b0;
		sample.chan  = osf_pkg::chan_t'(ch);
		sample.data  = r;
		sample_valid = v;
		activate     = act;
		update       = upd_req;
		update_en    = upd_mask;
		os_set       = osf_pkg::os_t'(upd_os);
		delay_set    = osf_pkg::delay_t'(upd_delay);
		model_step(v, ch, longint'(r));
	endtask

	// settings for one channel while it is inactive
	task automatic configure(input int c, input int os, input int dly);
		upd_req   = 1'b1;
		upd_mask  = N_CH'(1 << c);
		upd_os    = os;
		upd_delay = dly;
		run_cycle(0);
		upd_req  = 1'b0;
		upd_mask = '0;
	endtask

	function automatic bit words_pending();
		for (int c = 0; c < N_CH; c++)
			if (exp_q[c].size() != 0)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic drain();
		while (words_pending())
			run_cycle(0);
	endtask

	function automatic bit hold_windows_done();
		for (int c = 0; c < N_CH; c++)
			if (m_win[c] - win_base[c] < 2)
				return 1'b0;
		return 1'b1;
	endfunction

	////////////////////
	// test sequence
	////////////////////

	initial begin
		reset_in      = 1'b1;
		sample        = '0;
		sample_valid  = 1'b0;
		activate      = '0;
		update_en     = '0;
		update        = 1'b0;
		os_set        = '0;
		delay_set     = '0;
		credit_return = 1'b0;
		act      = '0;
		ch_mask  = '1;
		upd_mask = '0;
		upd_req  = 1'b0;
		hold     = 1'b0;
		cycles      = 0;
		outstanding = 0;
		for (int c = 0; c < N_CH; c++) begin
			m_state[c] = osf_pkg::OSF_IDLE;
			m_cnt[c]   = 0;
			m_acc[c]   = 0;
			m_os[c]    = 0;
			m_delay[c] = 0;
			m_win[c]   = 0;
		end
		void'($urandom(32'hec3));
		repeat (2) @(posedge clk_in);
		#1;
		reset_in = 1'b0;

		// all channels off while the bus stays busy
		repeat (200) run_cycle(1);

		// ratio 1 and no settling so samples pass straight through
		for (int c = 0; c < N_CH; c++)
			configure(c, 0, 0);
		act = '1;
		repeat (400) run_cycle(1);
		act = '0;
		drain();

		// random settings with the second round on a subset only
		for (int rnd = 0; rnd < 2; rnd++) begin
			round_mask = (rnd == 0) ? 4'hf : $urandom_range(1, 14);
			for (int c = 0; c < N_CH; c++)
				if (round_mask[c])
					configure(c, $urandom_range(4), $urandom_range(5));
			for (int c = 0; c < N_CH; c++)
				win_base[c] = m_win[c];
			act = '1;
			repeat (4000) run_cycle(1);
			act = '0;
			drain();
			for (int c = 0; c < N_CH; c++)
				if (m_win[c] - win_base[c] < 20)
					fail_now($sformatf("only %0d windows on channel %0d",
						m_win[c] - win_base[c], c));
		end

		// sink stalls for at most two windows per channel
		hold = 1'b1;
		for (int c = 0; c < N_CH; c++)
			win_base[c] = m_win[c];
		act = '1;
		while (!hold_windows_done()) begin
			for (int c = 0; c < N_CH; c++)
				ch_mask[c] = (m_win[c] - win_base[c] < 2);
			run_cycle(1);
		end
		act = '0;
		repeat (20) run_cycle(0);
		check("words held while stalled", outstanding, CREDITS);
		hold    = 1'b0;
		ch_mask = '1;
		drain();

		// drop channel 0 in the middle of a window and restart it
		configure(0, 3, 3);
		ch_mask = 4'b0001;
		act     = 4'b0001;
		while (!(m_state[0] == osf_pkg::OSF_SAMPLE && m_cnt[0] >= 2))
			run_cycle(1);
		act = '0;
		repeat (5) run_cycle(1);
		act = 4'b0001;
		repeat (600) run_cycle(1);
		act = '0;
		drain();

		// idle tail where no further word may arrive
		repeat (20) run_cycle(0);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== verification/osf_checker.sv ====
`timescale 1ns/1ps

module osf_checker #(
	parameter int CREDITS = 4
) (
	input  logic                              clk_in,
	input  logic                              reset_in,
	input  logic [$clog2(CREDITS + 1)-1:0]    credits,      // arbiter credit counter
	input  logic                              result_valid,
	input  logic [osf_pkg::N_CH-1:0]          overflow
);

	int fail_cnt = 0;   // failed assertions so far

	// a word goes out only if a credit was held on the granting edge
	a_send_with_credit: assert property (@(posedge clk_in) disable iff (reset_in)
		result_valid |-> ($past(credits) != '0))
		else begin
			$error("result word sent with no credit left");
			fail_cnt++;
		end

	// counter saturates at the initial value
	a_credit_max: assert property (@(posedge clk_in) disable iff (reset_in)
		credits <= CREDITS)
		else begin
			$error("credit count above the initial value");
			fail_cnt++;
		end

	a_no_overflow: assert property (@(posedge clk_in) disable iff (reset_in)
		overflow == '0)
		else begin
			$error("result buffer overflow");
			fail_cnt++;
		end

endmodule

// checker sits at the top level and reaches into the arbiter for its credit count
bind osf_top osf_checker #(
	.CREDITS(CREDITS)
) i_checker (
	.clk_in       (clk_in),
	.reset_in     (reset_in),
	.credits      (i_arbiter.credits),
	.result_valid (result_valid),
	.overflow     (overflow)
);

// ==== verilog/osf_top.sv ====
`timescale 1ns/1ps

module osf_top #(
	parameter int DEPTH   = 2,  // result buffer entries per channel
	parameter int CREDITS = 4   // initial sink credits
) (
	input  logic                      clk_in,
	input  logic                      reset_in,
	input  osf_pkg::osf_sample_t      sample,
	input  logic                      sample_valid,
	input  logic [osf_pkg::N_CH-1:0]  activate,
	input  logic [osf_pkg::N_CH-1:0]  update_en,
	input  logic                      update,
	input  osf_pkg::os_t              os_set,
	input  osf_pkg::delay_t           delay_set,
	input  logic                      credit_return,
	output osf_pkg::osf_result_t      result,
	output logic                      result_valid,
	output logic [osf_pkg::N_CH-1:0]  overflow
);

	osf_pkg::sample_t          avg [osf_pkg::N_CH];    // filter to buffer
	logic [osf_pkg::N_CH-1:0]  avg_valid;
	osf_pkg::sample_t          heads [osf_pkg::N_CH];  // buffer to arbiter
	logic [osf_pkg::N_CH-1:0]  not_empty;
	logic [osf_pkg::N_CH-1:0]  pop;

	////////////////////
	// channels
	////////////////////

	for (genvar i = 0; i < osf_pkg::N_CH; i++) begin : g_ch
		oversample_filter #(
			.CH_ID(i)
		) i_filter (
			.clk_in       (clk_in),
			.reset_in     (reset_in),
			.sample       (sample),        // shared bus, filter picks its tag
			.sample_valid (sample_valid),
			.activate     (activate[i]),
			.update_en    (update_en[i]),
			.update       (update),
			.os_set       (os_set),
			.delay_set    (delay_set),
			.avg          (avg[i]),
			.avg_valid    (avg_valid[i])
		);

		osf_result_buffer #(
			.DEPTH(DEPTH)
		) i_buffer (
			.clk_in    (clk_in),
			.reset_in  (reset_in),
			.push      (avg_valid[i]),
			.din       (avg[i]),
			.pop       (pop[i]),
			.head      (heads[i]),
			.not_empty (not_empty[i]),
			.overflow  (overflow[i])
		);
	end

	////////////////////
	// output arbiter
	////////////////////

	osf_credit_arbiter #(
		.CREDITS(CREDITS)
	) i_arbiter (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.heads         (heads),
		.not_empty     (not_empty),
		.pop           (pop),
		.credit_return (credit_return),
		.result        (result),
		.result_valid  (result_valid)
	);

endmodule

// ==== verilog/osf_credit_arbiter.sv ====
`timescale 1ns/1ps

module osf_credit_arbiter #(
	parameter int CREDITS = 4 // slots in the sink
) (
	input  logic                      clk_in,
	input  logic                      reset_in,
	input  osf_pkg::sample_t          heads [osf_pkg::N_CH],
	input  logic [osf_pkg::N_CH-1:0]  not_empty,
	output logic [osf_pkg::N_CH-1:0]  pop,
	input  logic                      credit_return,
	output osf_pkg::osf_result_t      result,
	output logic                      result_valid
);

	localparam int W_CRED = $clog2(CREDITS + 1);

	logic [W_CRED-1:0] credits;   // words the sink can still take
	osf_pkg::chan_t    last;      // channel served most recently
	osf_pkg::chan_t    sel;       // channel picked this cycle
	logic              found;
	logic              grant;     // send this cycle

	////////////////////
	// round robin pick
	////////////////////

	always_comb begin
		int idx;
		found = 1'b0;
		sel   = last;
		// search starts just after last, last itself comes at the end
		for (int i = 1; i <= osf_pkg::N_CH; i++) begin
			idx = (int'(last) + i) % osf_pkg::N_CH;
			if (!found && not_empty[idx]) begin
				found = 1'b1;
				sel   = osf_pkg::chan_t'(idx);
			end
		end
	end

	assign grant = found && (credits != '0);  // no credit means no send

	always_comb begin
		pop = '0;
		if (grant)
			pop[sel] = 1'b1;   // only the served buffer
	end

	////////////////////
	// credits and output
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			credits      <= W_CRED'(CREDITS);
			last         <= osf_pkg::chan_t'(osf_pkg::N_CH - 1); // channel 0 goes first
			result_valid <= 1'b0;
		end else begin
			result_valid <= grant;
			if (grant)
				last <= sel;
			case ({grant, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: begin
					if (credits < W_CRED'(CREDITS))
						credits <= credits + 1'b1; // saturate at the initial count
				end
				default: credits <= credits;   // send and return cancel
			endcase
		end
	end

	// output word
	always_ff @(posedge clk_in) begin
		if (grant) begin
			result.chan <= sel;
			result.data <= heads[sel];
		end
	end

endmodule

// ==== verilog/osf_result_buffer.sv ====
`timescale 1ns/1ps

module osf_result_buffer #(
	parameter int DEPTH = 2
) (
	input  logic             clk_in,
	input  logic             reset_in,
	input  logic             push,
	input  osf_pkg::sample_t din,
	input  logic             pop,
	output osf_pkg::sample_t head,
	output logic             not_empty,
	output logic             overflow
);

	localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int W_CNT = $clog2(DEPTH + 1);

	osf_pkg::sample_t mem [DEPTH];   // storage
	logic [W_PTR-1:0] rd_ptr;
	logic [W_PTR-1:0] wr_ptr;
	logic [W_CNT-1:0] fill;          // entries held
	logic             full;
	logic             do_push;
	logic             do_pop;

	// circular pointer step
	function automatic logic [W_PTR-1:0] ptr_inc(input logic [W_PTR-1:0] p);
		return (p == W_PTR'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full      = (fill == W_CNT'(DEPTH));
	assign not_empty = (fill != '0);
	assign head      = mem[rd_ptr];            // first word always visible
	assign do_pop    = pop && not_empty;
	assign do_push   = push && (!full || do_pop); // a pop frees the slot this edge

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			fill     <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			if (push && !do_push)
				overflow <= 1'b1;          // sticky until reset
		end
	end

	always_ff @(posedge clk_in) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

// ==== verilog/oversample_filter.sv ====
`timescale 1ns/1ps

module oversample_filter #(
	parameter int CH_ID = 0 // tag this filter listens to
) (
	input  logic                 clk_in,
	input  logic                 reset_in,
	input  osf_pkg::osf_sample_t sample,
	input  logic                 sample_valid,
	input  logic                 activate,
	input  logic                 update_en,
	input  logic                 update,
	input  osf_pkg::os_t         os_set,
	input  osf_pkg::delay_t      delay_set,
	output osf_pkg::sample_t     avg,
	output logic                 avg_valid
);

	////////////////////
	// internal signals
	////////////////////

	osf_pkg::osf_state_t state;
	osf_pkg::osf_state_t state_next;
	osf_pkg::osf_state_t settle_state;   // where a new window starts
	osf_pkg::os_t        os_cur;         // latched settings
	osf_pkg::delay_t     delay_cur;
	osf_pkg::delay_t     cnt;            // samples taken in current state
	osf_pkg::delay_t     cnt_next;
	osf_pkg::delay_t     win_last;       // count value of the closing sample
	osf_pkg::sum_t       acc;
	osf_pkg::sum_t       acc_next;
	osf_pkg::sum_t       sum_full;       // acc plus incoming sample
	osf_pkg::sum_t       sum_shr;
	osf_pkg::sample_t    din;
	logic                hit;            // valid sample for this channel
	logic                emit;           // closing sample of a window

	assign din      = sample.data;
	assign hit      = sample_valid && (sample.chan == osf_pkg::chan_t'(CH_ID));
	assign win_last = osf_pkg::delay_t'((1 << os_cur) - 1); // 2^os samples per window
	assign sum_full = acc + osf_pkg::sum_t'(din);            // sign extended add
	assign sum_shr  = sum_full >>> os_cur;                   // floor average

	// skip the delay state entirely when no settling is asked for
	assign settle_state = (delay_cur == '0) ? osf_pkg::OSF_SAMPLE : osf_pkg::OSF_DELAY;

	////////////////////
	// next state
	////////////////////

	always_comb begin
		state_next = state;
		cnt_next   = cnt;
		acc_next   = acc;
		emit       = 1'b0;
		if (!activate) begin
			// deactivation drops any partial window
			state_next = osf_pkg::OSF_IDLE;
			cnt_next   = '0;
			acc_next   = '0;
		end else begin
			case (state)
				osf_pkg::OSF_IDLE: begin
					state_next = settle_state;
					cnt_next   = '0;
					acc_next   = '0;
				end
				osf_pkg::OSF_DELAY: begin
					if (hit)
						cnt_next = cnt + 1'b1;     // discarded sample
					if (cnt_next >= delay_cur) begin
						state_next = osf_pkg::OSF_SAMPLE;
						cnt_next   = '0;
					end
				end
				osf_pkg::OSF_SAMPLE: begin
					if (hit) begin
						if (cnt >= win_last) begin
							// window closes on this sample
							emit       = 1'b1;
							state_next = settle_state;
							cnt_next   = '0;
							acc_next   = '0;
						end else begin
							acc_next = sum_full;
							cnt_next = cnt + 1'b1;
						end
					end
				end
				default: begin
					state_next = osf_pkg::OSF_IDLE;
				end
			endcase
		end
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state     <= osf_pkg::OSF_IDLE;
			cnt       <= '0;
			acc       <= '0;
			avg_valid <= 1'b0;
			os_cur    <= '0;
			delay_cur <= '0;
		end else begin
			state     <= state_next;
			cnt       <= cnt_next;
			acc       <= acc_next;
			avg_valid <= emit;           // one cycle after the closing sample
			if (update && update_en) begin
				os_cur    <= os_set;
				delay_cur <= delay_set;
			end
		end
	end

	// result payload, qualified by avg_valid
	always_ff @(posedge clk_in) begin
		if (emit)
			avg <= osf_pkg::sample_t'(sum_shr);
	end

endmodule

// ==== verilog/osf_pkg.sv ====
package osf_pkg;

	////////////////////
	// sizes
	////////////////////

	localparam int N_CH    = 4;                  // channels on the shared adc bus
	localparam int W_DATA  = 18;                 // adc sample and averaged result
	localparam int W_OS    = 3;                  // log2 of the oversample ratio
	localparam int MAX_OS  = 7;                  // largest os, ratio of 128
	localparam int W_SUM   = W_DATA + MAX_OS;    // accumulator never wraps
	localparam int W_CH    = $clog2(N_CH);       // channel tag
	localparam int W_DELAY = 16;                 // settling count

	////////////////////
	// types
	////////////////////

	typedef logic signed [W_DATA-1:0] sample_t;
	typedef logic signed [W_SUM-1:0]  sum_t;
	typedef logic [W_CH-1:0]          chan_t;
	typedef logic [W_OS-1:0]          os_t;
	typedef logic [W_DELAY-1:0]       delay_t;

	// per channel filter states
	typedef enum logic [1:0] {
		OSF_IDLE,    // channel off
		OSF_DELAY,   // throwing away settling samples
		OSF_SAMPLE   // summing a window
	} osf_state_t;

	typedef struct packed {
		chan_t   chan;   // which filter it belongs to
		sample_t data;
	} osf_sample_t;

	typedef struct packed {
		chan_t   chan;   // source channel of the average
		sample_t data;
	} osf_result_t;

endpackage
